/* src.f */
+incdir+design
design/ik_fixed_pkg.sv
design/ik_regmap_pkg.sv
design/split_word_bank.sv
design/ik_avalon_regs.sv
design/ik_step_core.sv
design/ik_accel_top.sv
bench/ik_accel_chk.sv
bench/ik_accel_tb.sv

/* Bender.yml */
package:
  name: ik_accel

sources:
  - include_dirs:
      - design
    files:
      - design/ik_fixed_pkg.sv
      - design/ik_regmap_pkg.sv
      - design/split_word_bank.sv
      - design/ik_avalon_regs.sv
      - design/ik_step_core.sv
      - design/ik_accel_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/ik_accel_chk.sv
      - bench/ik_accel_tb.sv

/* bench/ik_accel_tb.sv */
// ==============================
// directed testbench of the IK step accelerator
// every bus task starts and ends 1 ns after a rising edge
// ==============================

`timescale 1ns/1ps
`include "ik_consts.svh"

module ik_accel_tb;

	import ik_fixed_pkg::*;
	import ik_regmap_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int POLL_LIMIT = 64;
	localparam int LATENCY = `IK_JOINTS + 2;

	logic clk;
	logic reset;
	logic chipselect;
	logic write;
	reg_addr_t address;
	logic [31:0] writedata;
	logic [31:0] readdata;

	int errors;
	int assert_fails;
	logic [15:0] lfsr_state;
	vec3_t tgt_model;
	dh_table_t dh_model_in;
	dh_table_t dh_expect;

	ik_accel_top i_ik_accel_top (
		.clk(clk),
		.reset(reset),
		.chipselect(chipselect),
		.write(write),
		.address(address),
		.writedata(writedata),
		.readdata(readdata)
	);

	always #4 clk = ~clk;

	initial begin
		repeat (2000 * NUM_TESTS) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", 2000 * NUM_TESTS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// 16-bit Galois LFSR
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	function automatic fx_t rand_fx();
		fx_t v;
		for (int i = 0; i < `IK_WORD_W; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [35:0] got,
		input logic [35:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic bus_write(input reg_addr_t addr, input logic [31:0] data);
		chipselect = 1'b1;
		write = 1'b1;
		address = addr;
		writedata = data;
		@(posedge clk);
		#1;
		chipselect = 1'b0;
		write = 1'b0;
	endtask

	task automatic bus_read(input reg_addr_t addr, output logic [31:0] data);
		chipselect = 1'b1;
		write = 1'b0;
		address = addr;
		@(posedge clk);
		#1;
		data = readdata;
		chipselect = 1'b0;
	endtask

	// addr is the even address holding the high nibble
	task automatic write_fx(input reg_addr_t addr, input fx_t value);
		bus_write(addr + 6'd1, value[31:0]);
		bus_write(addr, {28'b0, value[35:32]});
	endtask

	task automatic read_fx(input reg_addr_t addr, output fx_t value);
		logic [31:0] lo;
		logic [31:0] hi;
		bus_read(addr + 6'd1, lo);
		bus_read(addr, hi);
		check_value("readdata[31:4] of high half", 36'(hi[31:4]), 36'd0);
		value = {hi[3:0], lo};
	endtask

	function automatic reg_addr_t target_addr(input int k);
		return reg_addr_t'(REG_TARGET_BASE + 2 * k);
	endfunction

	function automatic reg_addr_t dh_addr(input int j, input int f);
		return reg_addr_t'(REG_DH_BASE + 8 * j + 2 * f);
	endfunction

	// prismatic chain along z, offsets give z and distances give x
	function automatic dh_table_t step_model(input dh_table_t d, input vec3_t t);
		dh_table_t r;
		fx_t z_sum;
		fx_t x_sum;
		fx_t ez;
		fx_t ex;
		z_sum = '0;
		x_sum = '0;
		for (int j = 0; j < `IK_JOINTS; j++) begin
			z_sum = z_sum + d[j][L_OFFSET];
			x_sum = x_sum + d[j][L_DISTANCE];
		end
		ez = t[VEC_Z] - z_sum;
		ex = t[VEC_X] - x_sum;
		ez = ez >>> `IK_GAIN_SHIFT;
		ex = ex >>> `IK_GAIN_SHIFT;
		r = d;
		for (int j = 0; j < `IK_JOINTS; j++) begin
			r[j][L_OFFSET] = d[j][L_OFFSET] + ez;
			r[j][L_DISTANCE] = d[j][L_DISTANCE] + ex;
		end
		return r;
	endfunction

	task automatic load_inputs();
		for (int k = 0; k < 3; k++) begin
			write_fx(target_addr(k), tgt_model[k]);
		end
		for (int j = 0; j < `IK_JOINTS; j++) begin
			for (int f = 0; f < 4; f++) begin
				write_fx(dh_addr(j, f), dh_model_in[j][f]);
			end
		end
	endtask

	task automatic check_rows();
		fx_t v;
		for (int j = 0; j < `IK_JOINTS; j++) begin
			for (int f = 0; f < 4; f++) begin
				read_fx(dh_addr(j, f), v);
				check_value($sformatf("dh_out[%0d][%0d]", j, f), v, dh_expect[j][f]);
			end
		end
	endtask

	// done must read low once before it counts, a stale done reads first
	task automatic wait_done(output int polls, output logic saw_busy);
		logic [31:0] status;
		logic cleared;
		polls = 0;
		saw_busy = 1'b0;
		cleared = 1'b0;
		status = '0;
		while (!(cleared && status[0]) && polls < POLL_LIMIT) begin
			bus_read(REG_STATUS, status);
			polls++;
			if (!status[0]) begin
				cleared = 1'b1;
			end
			if (status[1]) begin
				saw_busy = 1'b1;
			end
		end
		if (!(cleared && status[0])) begin
			errors++;
			$display("done did not clear and rise again within %0d status polls", POLL_LIMIT);
		end
	endtask

	task automatic run_step();
		int polls;
		logic saw_busy;
		bus_write(REG_START, 32'h1);
		wait_done(polls, saw_busy);
		dh_expect = step_model(dh_model_in, tgt_model);
		check_rows();
	endtask

	task automatic reset_state_test();
		logic [31:0] data;
		fx_t v;
		bus_read(REG_STATUS, data);
		check_value("status", 36'(data), 36'd0);
		for (int k = 0; k < 3; k++) begin
			read_fx(target_addr(k), v);
			check_value($sformatf("target[%0d]", k), v, 36'd0);
		end
		dh_expect = '0;
		check_rows();
		for (int a = 8; a < 16; a++) begin
			bus_read(reg_addr_t'(a), data);
			check_value($sformatf("reserved[%0d]", a), 36'(data), 36'd0);
		end
	endtask

	task automatic target_access_test();
		fx_t v;
		for (int k = 0; k < 3; k++) begin
			tgt_model[k] = rand_fx();
		end
		tgt_model[VEC_X][35] = 1'b1;
		for (int k = 0; k < 3; k++) begin
			write_fx(target_addr(k), tgt_model[k]);
		end
		for (int k = 0; k < 3; k++) begin
			read_fx(target_addr(k), v);
			check_value($sformatf("target[%0d]", k), v, tgt_model[k]);
		end
		// low write alone leaves bits 35:32 cleared
		v = rand_fx();
		bus_write(target_addr(VEC_X) + 6'd1, v[31:0]);
		tgt_model[VEC_X] = {4'h0, v[31:0]};
		read_fx(target_addr(VEC_X), v);
		check_value("target[0] after low write", v, tgt_model[VEC_X]);
	endtask

	task automatic step_result_test();
		fx_t v;
		for (int j = 0; j < `IK_JOINTS; j++) begin
			for (int f = 0; f < 4; f++) begin
				dh_model_in[j][f] = rand_fx();
			end
		end
		for (int k = 0; k < 3; k++) begin
			tgt_model[k] = rand_fx();
		end
		load_inputs();
		run_step();
		// both errors negative, z error not a multiple of four
		for (int j = 0; j < `IK_JOINTS; j++) begin
			dh_model_in[j][L_OFFSET] = FX_ONE;
			dh_model_in[j][L_DISTANCE] = '0;
		end
		tgt_model[VEC_Z] = 3 * FX_ONE + 1;
		tgt_model[VEC_X] = '1;
		load_inputs();
		run_step();
		read_fx(dh_addr(0, int'(L_OFFSET)), v);
		check_value("dh_out[0][offset]", v, 36'h0_0000_4000);
		read_fx(dh_addr(0, int'(L_DISTANCE)), v);
		check_value("dh_out[0][distance]", v, 36'hF_FFFF_FFFF);
	endtask

	task automatic status_timing_test();
		int polls;
		logic saw_busy;
		bus_write(REG_START, 32'h1);
		wait_done(polls, saw_busy);
		check_value("status busy seen", 36'(saw_busy), 36'd1);
		check_value("done latency", 36'(polls - 1), 36'(LATENCY));
	endtask

	task automatic restart_test();
		int polls;
		logic saw_busy;
		logic [31:0] status;
		// second start is sampled two edges after the first
		bus_write(REG_START, 32'h1);
		bus_read(REG_STATUS, status);
		bus_write(REG_START, 32'h1);
		wait_done(polls, saw_busy);
		check_value("restart latency", 36'(polls + 1), 36'(LATENCY));
		for (int i = 0; i < 4; i++) begin
			bus_read(REG_STATUS, status);
			check_value("status after ignored start", 36'(status), 36'd1);
		end
		dh_expect = step_model(dh_model_in, tgt_model);
		check_rows();
		dh_model_in = dh_expect;
		load_inputs();
		run_step();
	endtask

	task automatic reserved_space_test();
		logic [31:0] data;
		fx_t v;
		for (int a = 8; a < 16; a++) begin
			v = rand_fx();
			bus_write(reg_addr_t'(a), v[31:0] | 32'h1);
			bus_read(reg_addr_t'(a), data);
			check_value($sformatf("reserved[%0d]", a), 36'(data), 36'd0);
		end
		bus_read(REG_STATUS, data);
		check_value("status after reserved writes", 36'(data), 36'd1);
		for (int k = 0; k < 3; k++) begin
			read_fx(target_addr(k), v);
			check_value($sformatf("target[%0d]", k), v, tgt_model[k]);
		end
		check_rows();
		// the DH bank is only visible through a new step
		run_step();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		chipselect = 1'b0;
		write = 1'b0;
		address = '0;
		writedata = '0;
		errors = 0;
		lfsr_state = 16'd45969;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		reset_state_test();
		target_access_test();
		step_result_test();
		status_timing_test();
		restart_test();
		reserved_space_test();
		assert_fails = i_ik_accel_top.i_ik_accel_chk.fail_count;
		$display("%0d check errors, %0d assertion failures", errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* bench/ik_accel_chk.sv */
// ==============================
// bus and status assertions, bound into ik_accel_top
// the busy bound covers one single-step run
// ==============================

`timescale 1ns/1ps
`include "ik_consts.svh"

module ik_accel_chk (
	input logic clk,
	input logic reset,
	input logic [31:0] readdata,
	input logic busy,
	input logic done
);

	// number of assertion failures
	int fail_count = 0;

	a_readdata_reset: assert property (@(posedge clk) $past(reset) |-> readdata == '0)
	else begin
		fail_count++;
		$error("readdata not zero in the cycle after reset");
	end

	// one step ends within IK_JOINTS + 2 cycles
	a_busy_length: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> ##[1:`IK_JOINTS + 2] !busy)
	else begin
		fail_count++;
		$error("busy stayed high longer than one step");
	end

	a_done_busy: assert property (@(posedge clk) disable iff (reset) !(done && busy))
	else begin
		fail_count++;
		$error("done and busy high together");
	end

endmodule

bind ik_accel_top ik_accel_chk i_ik_accel_chk (
	.clk(clk),
	.reset(reset),
	.readdata(readdata),
	.busy(busy),
	.done(done)
);

/* design/ik_accel_top.sv */
// ==============================
// IK step accelerator behind a 64-word slave bus
// target and DH input live in two split-word banks
// ==============================

`timescale 1ns/1ps

module ik_accel_top (
	input logic clk,
	input logic reset,
	input logic chipselect,
	input logic write,
	input ik_regmap_pkg::reg_addr_t address,
	input logic [31:0] writedata,
	output logic [31:0] readdata
);

	import ik_fixed_pkg::*;

	localparam int TGT_WORDS = $bits(vec3_t) / $bits(fx_t);
	localparam int DH_WORDS = $bits(dh_table_t) / $bits(fx_t);

	logic tgt_wr_en;
	logic dh_wr_en;
	logic wr_high;
	logic [4:0] wr_index;
	logic [31:0] wr_data;
	logic start_pulse;
	logic busy;
	logic done;
	vec3_t target;
	dh_table_t dh_in;
	dh_table_t dh_out;

	ik_avalon_regs i_ik_avalon_regs (
		.clk(clk),
		.reset(reset),
		.chipselect(chipselect),
		.write(write),
		.address(address),
		.writedata(writedata),
		.readdata(readdata),
		.tgt_wr_en(tgt_wr_en),
		.dh_wr_en(dh_wr_en),
		.wr_high(wr_high),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.start_pulse(start_pulse),
		.target(target),
		.dh_out(dh_out),
		.busy(busy),
		.done(done)
	);

	// target bank needs only the low index bits
	split_word_bank #(
		.entry_t(vec3_t),
		.WORDS(TGT_WORDS)
	) i_target_bank (
		.clk(clk),
		.reset(reset),
		.wr_en(tgt_wr_en),
		.wr_index(wr_index[$clog2(TGT_WORDS)-1:0]),
		.wr_high(wr_high),
		.wr_data(wr_data),
		.contents(target)
	);

	split_word_bank #(
		.entry_t(dh_table_t),
		.WORDS(DH_WORDS)
	) i_dh_bank (
		.clk(clk),
		.reset(reset),
		.wr_en(dh_wr_en),
		.wr_index(wr_index),
		.wr_high(wr_high),
		.wr_data(wr_data),
		.contents(dh_in)
	);

	ik_step_core i_ik_step_core (
		.clk(clk),
		.reset(reset),
		.start_pulse(start_pulse),
		.target(target),
		.dh_in(dh_in),
		.dh_out(dh_out),
		.busy(busy),
		.done(done)
	);

endmodule

/* design/ik_step_core.sv */
// ==============================
// one Jacobian-transpose step for a prismatic chain along z
// done rises IK_JOINTS + 1 edges after start_pulse is taken
// dh_in must stay stable while busy
// ==============================

`timescale 1ns/1ps
`include "ik_consts.svh"

module ik_step_core (
	input logic clk,
	input logic reset,
	input logic start_pulse,
	input ik_fixed_pkg::vec3_t target,
	input ik_fixed_pkg::dh_table_t dh_in,
	output ik_fixed_pkg::dh_table_t dh_out,
	output logic busy,
	output logic done
);

	import ik_fixed_pkg::*;
	import ik_regmap_pkg::*;

	localparam int JW = $clog2(`IK_JOINTS + 1);
	localparam logic [JW-1:0] LAST_JOINT = JW'(`IK_JOINTS - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ACC,
		S_ERR,
		S_UPD
	} state_e;

	state_e state;
	logic [JW-1:0] joint;
	logic start_ok;
	fx_t sum_off;
	fx_t sum_dist;
	fx_t err_z;
	fx_t err_x;
	fx_t step_z;
	fx_t step_x;

	assign busy = (state != S_IDLE);
	assign start_ok = (state == S_IDLE) && start_pulse;

	// end effector z is the offset sum, x the distance sum
	assign err_z = target[VEC_Z] - sum_off;
	assign err_x = target[VEC_X] - sum_dist;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			joint <= '0;
			done <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start_pulse) begin
						// row 0 is summed on this edge
						state <= S_ACC;
						joint <= JW'(1);
						done <= 1'b0;
					end
				end
				S_ACC: begin
					if (joint == LAST_JOINT) begin
						state <= S_ERR;
					end
					joint <= joint + 1'b1;
				end
				S_ERR: begin
					state <= S_UPD;
				end
				S_UPD: begin
					state <= S_IDLE;
					done <= 1'b1;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// accumulators and scaled errors, all wrapping at 36 bits
	always_ff @(posedge clk) begin
		if (start_ok) begin
			sum_off <= dh_in[0][L_OFFSET];
			sum_dist <= dh_in[0][L_DISTANCE];
		end else if (state == S_ACC) begin
			sum_off <= sum_off + dh_in[joint][L_OFFSET];
			sum_dist <= sum_dist + dh_in[joint][L_DISTANCE];
		end
		if (state == S_ERR) begin
			step_z <= err_z >>> `IK_GAIN_SHIFT;
			step_x <= err_x >>> `IK_GAIN_SHIFT;
		end
	end

	// every joint moves by the same step, angles pass through
	always_ff @(posedge clk) begin
		if (reset) begin
			dh_out <= '0;
		end else if (state == S_UPD) begin
			for (int j = 0; j < `IK_JOINTS; j++) begin
				dh_out[j][THETA] <= dh_in[j][THETA];
				dh_out[j][L_OFFSET] <= dh_in[j][L_OFFSET] + step_z;
				dh_out[j][L_DISTANCE] <= dh_in[j][L_DISTANCE] + step_x;
				dh_out[j][ALPHA] <= dh_in[j][ALPHA];
			end
		end
	end

endmodule

/* design/ik_avalon_regs.sv */
// ==============================
// Avalon-style slave of the IK accelerator
// no wait states, readdata is valid one clock after a read
// a start while busy is dropped
// ==============================

`timescale 1ns/1ps

module ik_avalon_regs (
	input logic clk,
	input logic reset,
	input logic chipselect,
	input logic write,
	input ik_regmap_pkg::reg_addr_t address,
	input logic [31:0] writedata,
	output logic [31:0] readdata,
	output logic tgt_wr_en,
	output logic dh_wr_en,
	output logic wr_high,
	output logic [4:0] wr_index,
	output logic [31:0] wr_data,
	output logic start_pulse,
	input ik_fixed_pkg::vec3_t target,
	input ik_fixed_pkg::dh_table_t dh_out,
	input logic busy,
	input logic done
);

	import ik_fixed_pkg::*;
	import ik_regmap_pkg::*;

	localparam int TGT_WORDS = $bits(vec3_t) / $bits(fx_t);
	localparam int HI_W = $bits(fx_t) - 32;

	logic wr_acc;
	logic rd_acc;
	logic in_target;
	logic in_dh;
	logic [4:0] word_addr;
	logic [4:0] word_idx;
	fx_t rd_word;

	assign wr_acc = chipselect && write;
	assign rd_acc = chipselect && !write;

	// 8 to 15 fall in neither range
	assign in_target = (address >= REG_TARGET_BASE) &&
		(address < REG_TARGET_BASE + 2 * TGT_WORDS);
	assign in_dh = (address >= REG_DH_BASE);

	// two bus addresses per 36-bit word
	assign word_addr = address[5:1];
	assign word_idx = in_dh ? word_addr - 5'(REG_DH_BASE >> 1) :
		word_addr - 5'(REG_TARGET_BASE >> 1);

	// bank write strobes, taken on the same edge as the bus write
	assign tgt_wr_en = wr_acc && in_target;
	assign dh_wr_en = wr_acc && in_dh;
	assign wr_high = !address[0];
	assign wr_index = word_idx;
	assign wr_data = writedata;

	always_ff @(posedge clk) begin
		if (reset) begin
			start_pulse <= 1'b0;
		end else begin
			start_pulse <= wr_acc && (address == REG_START) && writedata[0] && !busy;
		end
	end

	// DH word index is 4*joint + field
	always_comb begin
		rd_word = '0;
		if (in_target) begin
			rd_word = target[word_idx[1:0]];
		end else if (in_dh) begin
			rd_word = dh_out[word_idx[4:2]][word_idx[1:0]];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			readdata <= '0;
		end else if (rd_acc) begin
			if (address == REG_STATUS || address == REG_START) begin
				readdata <= {30'b0, busy, done};
			end else if (wr_high) begin
				readdata <= {{(32 - HI_W){1'b0}}, rd_word[$bits(fx_t)-1:32]};
			end else begin
				readdata <= rd_word[31:0];
			end
		end
	end

endmodule

/* design/split_word_bank.sv */
// ==============================
// bank of signed words written over a 32-bit bus
// a low write clears bits 35:32, so write low then high
// entry_t must be exactly WORDS words wide
// ==============================

`timescale 1ns/1ps
`include "ik_consts.svh"

module split_word_bank #(
	parameter type entry_t = logic [2*`IK_WORD_W-1:0],
	parameter int WORDS = 2
) (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input logic [$clog2(WORDS)-1:0] wr_index,
	input logic wr_high,
	input logic [31:0] wr_data,
	output entry_t contents
);

	localparam int HI_W = `IK_WORD_W - 32;

	// word k sits at bits [k*IK_WORD_W +: IK_WORD_W]
	logic signed [WORDS-1:0][`IK_WORD_W-1:0] words;

	always_ff @(posedge clk) begin
		if (reset) begin
			words <= '0;
		end else if (wr_en) begin
			if (wr_high) begin
				// only the top nibble changes
				words[wr_index][`IK_WORD_W-1:32] <= wr_data[HI_W-1:0];
			end else begin
				words[wr_index] <= {{HI_W{1'b0}}, wr_data};
			end
		end
	end

	// same bits, viewed as the payload type
	assign contents = entry_t'(words);

endmodule

/* design/ik_regmap_pkg.sv */
// ==============================
// register map of the slave bus
// even address holds bits 35:32, odd address bits 31:0
// 8 to 15 are reserved and read zero
// ==============================

`include "ik_consts.svh"

package ik_regmap_pkg;

	// bus word address
	typedef logic [`IK_ADDR_W-1:0] reg_addr_t;

	// field within one DH row, also the row index
	typedef enum logic [1:0] {
		THETA,
		L_OFFSET,
		L_DISTANCE,
		ALPHA
	} dh_field_e;

	// address 0 and 1 both read the status word
	localparam reg_addr_t REG_STATUS = 0;
	localparam reg_addr_t REG_START = 1;

	// x, y, z as three split words
	localparam reg_addr_t REG_TARGET_BASE = 2;

	// joint j starts at REG_DH_BASE + 8*j
	localparam reg_addr_t REG_DH_BASE = 16;

endpackage

/* design/ik_fixed_pkg.sv */
// ==============================
// fixed-point data types of the IK core
// arrays are indexed from the LSB end, element 0 is lowest
// ==============================

`include "ik_consts.svh"

package ik_fixed_pkg;

	// two's complement, IK_FRAC_W fraction bits
	typedef logic signed [`IK_WORD_W-1:0] fx_t;

	localparam fx_t FX_ONE = fx_t'(1) <<< `IK_FRAC_W;

	// one DH row, indexed by dh_field_e
	// order theta, offset, distance, alpha from index 0 up
	typedef fx_t [3:0] dh_row_t;

	// whole chain, row 0 is the base joint
	typedef dh_row_t [`IK_JOINTS-1:0] dh_table_t;

	// target position, index 0 is x
	typedef fx_t [2:0] vec3_t;

	localparam int VEC_X = 0;
	localparam int VEC_Y = 1;
	localparam int VEC_Z = 2;

endpackage

/* design/ik_consts.svh */
// ==============================
// shared sizing macros for the IK step accelerator
// the bus split assumes IK_WORD_W is 36 (4 high bits, 32 low bits)
// the step core assumes at least two joints
// ==============================

`ifndef IK_CONSTS_SVH
`define IK_CONSTS_SVH

// joints in the serial chain
`define IK_JOINTS 6

// fixed-point word width and fraction bits, 65536 means 1.0
`define IK_WORD_W 36
`define IK_FRAC_W 16

// step gain is 2^-IK_GAIN_SHIFT
`define IK_GAIN_SHIFT 2

// word address width of the slave bus
`define IK_ADDR_W 6

`endif
